//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := ccd_pipe_tb
FILELIST := ccd_pipe.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the binary is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/ccd_pipe_sva.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

module ccd_pipe_sva (
  input logic        ccd_pixel_clk,
  input logic        arst_n,
  input logic        rgb_mode,
  input logic        pixel_write,
  input logic [15:0] pixel_word,
  input logic        rate_pulse
);

  logic        pulse_d;  // rate_pulse one clock back
  logic [15:0] gap_cnt;  // Clocks since the last toggle, saturating

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      pulse_d <= 1'b0;
      gap_cnt <= '0;
    end else begin
      pulse_d <= rate_pulse;
      if (rate_pulse != pulse_d) gap_cnt <= '0;
      else if (gap_cnt != '1) gap_cnt <= gap_cnt + 1'b1;
    end
  end

  // ====================
  // Port checks
  // ====================
  a_no_write_in_reset: assert property (@(posedge ccd_pixel_clk)
    (!arst_n || !$past(arst_n) || !$past(arst_n, 2)) |-> !pixel_write)
  else $error("pixel_write high during reset or right after it");

  a_top_bit_zero: assert property (@(posedge ccd_pixel_clk) disable iff (!arst_n)
    pixel_write |-> !pixel_word[15])
  else $error("pixel_word bit 15 set on a write");

  // Hue words only use the low byte
  a_hue_upper_zero: assert property (@(posedge ccd_pixel_clk) disable iff (!arst_n)
    (pixel_write && !rgb_mode) |-> (pixel_word[15:8] == 8'h00))
  else $error("pixel_word upper byte not zero in hue mode");

  a_pulse_once: assert property (@(posedge ccd_pixel_clk) disable iff (!arst_n)
    (rate_pulse != pulse_d) |-> (gap_cnt >= 16'(`CAM_RATE_TICKS - 1)))
  else $error("rate_pulse toggled twice within one window");

endmodule : ccd_pipe_sva

bind ccd_pipe_top ccd_pipe_sva ccd_pipe_sva_i (.*);

`default_nettype wire

//--- bench/ccd_pipe_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

module ccd_pipe_tb
  import cam_pkg::*;
  import pix_pkg::*;
();

  // ====================
  // Test geometry
  // ====================
  localparam int CLK_NS     = 8;
  localparam int IMG_W      = 16;
  localparam int IMG_H      = 8;
  localparam int LINE_GAP   = 6;    // lval low between lines
  localparam int FRAME_GAP  = 40;   // fval low after a frame
  localparam int NUM_FRAMES = 12;
  localparam int FRAME_LEN  = 1 + LINE_GAP + IMG_H * (IMG_W + LINE_GAP) + FRAME_GAP;
  localparam int TILES      = (IMG_W / 2) * (IMG_H / 2);  // Words per captured frame
  localparam longint WATCHDOG_NS =
    longint'(NUM_FRAMES * FRAME_LEN * 2 + 3 * `CAM_RATE_TICKS) * CLK_NS;

  logic                  ccd_pixel_clk;
  logic                  arst_n;
  logic [`CAM_RAW_W-1:0] ccd_data;
  logic                  ccd_fval;
  logic                  ccd_lval;
  logic                  start;
  logic                  rgb_mode;
  coord_t                width;
  coord_t                height;
  pix_word_t             pixel_word;
  logic                  pixel_write;
  logic [`CAM_CNT_W-1:0] frame_count;
  logic [`CAM_CNT_W-1:0] frame_rate;
  logic                  rate_pulse;

  logic [15:0]           lfsr;                       // Sample source
  logic [`CAM_RAW_W-1:0] frame_pix [IMG_H][IMG_W];   // Frame being driven
  pix_word_t             exp_q [$];                  // Reference words, oldest first
  pix_word_t             exp_word;
  int                    write_count;
  int                    exp_frames;                 // Captured frames so far
  int                    toggles;
  logic                  pulse_prev;
  logic [`CAM_CNT_W-1:0] fc_prev;                    // frame_count one clock back
  logic [`CAM_CNT_W-1:0] fc_at_toggle;

  always #(CLK_NS / 2) ccd_pixel_clk = ~ccd_pixel_clk;

  ccd_pipe_top ccd_pipe_top_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .start         (start),
    .rgb_mode      (rgb_mode),
    .width         (width),
    .height        (height),
    .pixel_word    (pixel_word),
    .pixel_write   (pixel_write),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_pulse    (rate_pulse)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expd);
    fail_now($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                       $time, name, got, expd));
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, shifting right
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  task automatic draw_sample(output logic [`CAM_RAW_W-1:0] val);
    val = '0;
    for (int i = 0; i < `CAM_RAW_W; i++) begin
      val  = {val[`CAM_RAW_W-2:0], lfsr[0]};  // One step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Hue on the top 8 bits of each 12-bit component
  function automatic hue_t model_hue(input int r12, input int g12, input int b12);
    int r;
    int g;
    int b;
    int mx;
    int mn;
    int sd;
    int off;
    r = r12 >> 4;
    g = g12 >> 4;
    b = b12 >> 4;
    if (r >= g && r >= b) begin
      mx  = r;
      mn  = (g < b) ? g : b;
      sd  = g - b;
      off = 0;
    end else if (g >= b) begin
      mx  = g;
      mn  = (r < b) ? r : b;
      sd  = b - r;
      off = 85;
    end else begin
      mx  = b;
      mn  = (r < g) ? r : g;
      sd  = r - g;
      off = 171;
    end
    if (mx == mn) return 8'd0;              // Gray
    return hue_t'((off + (43 * sd) / (mx - mn)) & 255);  // Int divide truncates to zero
  endfunction

  // Random frame with every other 2x2 tile flat when gray is set
  task automatic build_frame(input bit gray);
    logic [`CAM_RAW_W-1:0] v;
    for (int y = 0; y < IMG_H; y++) begin
      for (int x = 0; x < IMG_W; x++) begin
        draw_sample(v);
        frame_pix[y][x] = v;
      end
    end
    if (gray) begin
      for (int ty = 0; ty < IMG_H / 2; ty++) begin
        for (int tx = 0; tx < IMG_W / 2; tx += 2) begin
          v = frame_pix[2*ty][2*tx];
          frame_pix[2*ty][2*tx+1]   = v;
          frame_pix[2*ty+1][2*tx]   = v;
          frame_pix[2*ty+1][2*tx+1] = v;
        end
      end
    end
  endtask

  // One word per GR/BG tile in row-major order
  task automatic queue_expected(input bit mode);
    int r;
    int g;
    int b;
    for (int ty = 0; ty < IMG_H / 2; ty++) begin
      for (int tx = 0; tx < IMG_W / 2; tx++) begin
        r = frame_pix[2*ty][2*tx+1];
        b = frame_pix[2*ty+1][2*tx];
        g = (int'(frame_pix[2*ty][2*tx]) + int'(frame_pix[2*ty+1][2*tx+1])) >> 1;
        if (mode) exp_q.push_back({1'b0, r[11:7], g[11:7], b[11:7]});
        else exp_q.push_back({8'h00, model_hue(r, g, b)});
      end
    end
  endtask

  task automatic drive_pins(input logic [`CAM_RAW_W-1:0] d, input logic fv, input logic lv);
    @(negedge ccd_pixel_clk);
    ccd_data = d;
    ccd_fval = fv;
    ccd_lval = lv;
  endtask

  // ====================
  // One frame plus gap
  // ====================
  task automatic run_frame(input bit capture, input bit mode, input bit gray, input bit drop);
    int writes_before;
    build_frame(gray);
    if (capture) begin
      queue_expected(mode);
      exp_frames++;
    end
    writes_before = write_count;
    @(negedge ccd_pixel_clk);
    start    = capture;  // Set while fval is still low
    rgb_mode = mode;
    repeat (LINE_GAP) drive_pins('0, 1'b1, 1'b0);
    for (int y = 0; y < IMG_H; y++) begin
      if (drop && y == IMG_H / 2) start = 1'b0;  // Frame must still complete
      for (int x = 0; x < IMG_W; x++) drive_pins(frame_pix[y][x], 1'b1, 1'b1);
      repeat (LINE_GAP) drive_pins('0, 1'b1, 1'b0);
    end
    repeat (FRAME_GAP) drive_pins('0, 1'b0, 1'b0);
    assert (write_count - writes_before == (capture ? TILES : 0))
    else fail_now($sformatf("frame gave %0d writes where %0d were expected",
                            write_count - writes_before, capture ? TILES : 0));
    assert (frame_count == exp_frames)
    else report_mismatch("frame_count", frame_count, exp_frames);
  endtask

  // Output words against the reference queue
  always @(negedge ccd_pixel_clk) begin
    if (arst_n && pixel_write) begin
      write_count++;
      if (exp_q.size() == 0) begin
        fail_now("pixel_write seen with no expected word pending");
      end else begin
        exp_word = exp_q.pop_front();
        assert (pixel_word == exp_word)
        else report_mismatch("pixel_word", pixel_word, exp_word);
      end
    end
  end

  // Rate meter against the count seen since the last toggle
  always @(negedge ccd_pixel_clk) begin
    if (arst_n) begin
      if (rate_pulse != pulse_prev) begin
        assert (frame_rate == fc_prev - fc_at_toggle)
        else report_mismatch("frame_rate", frame_rate, fc_prev - fc_at_toggle);
        fc_at_toggle = fc_prev;
        toggles++;
      end
      pulse_prev = rate_pulse;
      fc_prev    = frame_count;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_now("watchdog expired before the test sequence finished");
  end

  initial begin
    ccd_pixel_clk = 1'b0;
    arst_n        = 1'b0;
    ccd_data      = '0;
    ccd_fval      = 1'b0;
    ccd_lval      = 1'b0;
    start         = 1'b0;
    rgb_mode      = 1'b1;
    width         = coord_t'(IMG_W);
    height        = coord_t'(IMG_H);
    lfsr          = 16'd25583;
    write_count   = 0;
    exp_frames    = 0;
    toggles       = 0;
    pulse_prev    = 1'b0;
    fc_prev       = '0;
    fc_at_toggle  = '0;
    repeat (8) @(negedge ccd_pixel_clk);
    arst_n = 1'b1;

    run_frame(0, 1, 0, 0);  // Start low, nothing captured
    run_frame(0, 1, 0, 0);
    run_frame(1, 1, 0, 0);  // RGB555
    run_frame(1, 1, 1, 0);
    run_frame(1, 1, 0, 0);
    run_frame(1, 1, 0, 1);  // Start drops mid-frame
    run_frame(1, 0, 1, 0);  // Hue with gray tiles
    run_frame(1, 0, 0, 0);
    run_frame(1, 0, 0, 0);
    run_frame(0, 0, 0, 0);
    run_frame(1, 0, 1, 0);
    run_frame(1, 0, 0, 0);

    wait (toggles >= 2);  // One window with frames, one without
    @(negedge ccd_pixel_clk);
    if (exp_q.size() != 0) begin
      fail_now($sformatf("%0d expected words were never written", exp_q.size()));
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule : ccd_pipe_tb

`default_nettype wire

//--- ccd_pipe.f
+incdir+src
src/cam_pkg.sv
src/pix_pkg.sv
src/cam_stream_if.sv
src/video_delay.sv
src/capture_ctrl.sv
src/bayer_demosaic.sv
src/hue_calc.sv
src/pixel_packer.sv
src/ccd_pipe_top.sv
bench/ccd_pipe_sva.sv
bench/ccd_pipe_tb.sv

//--- src/bayer_demosaic.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

// Bayer tile:  G R  (even row)
//              B G  (odd row)
module bayer_demosaic (
  input  logic ccd_pixel_clk,
  input  logic arst_n,
  cap_if.dst   cap,
  rgb_if.src   rgb
);

  localparam int AW = $clog2(`CAM_LINE_MAX);
  localparam int RW = `CAM_RAW_W;

  logic [RW-1:0] line_mem [`CAM_LINE_MAX];  // Last even row
  logic [AW-1:0] addr;
  logic [RW-1:0] line_rd;     // Even-row sample above this one
  logic [RW-1:0] buf_prev;    // Even-row sample above and left
  logic [RW-1:0] samp_prev;   // Previous sample on this row
  logic [RW:0]   green_sum;   // One extra bit for the carry
  logic          odd_row;
  logic          odd_pix;     // Bottom-right of a 2x2 tile
  logic          valid_q;
  logic [RW-1:0] red_q;
  logic [RW-1:0] green_q;
  logic [RW-1:0] blue_q;

  assign addr      = cap.x[AW-1:0];
  assign line_rd   = line_mem[addr];
  assign odd_row   = cap.y[0];
  assign odd_pix   = cap.valid & odd_row & cap.x[0];
  assign green_sum = buf_prev + cap.data;

  // Even rows fill the buffer, odd rows only read it
  always_ff @(posedge ccd_pixel_clk) begin
    if (cap.valid && !odd_row) line_mem[addr] <= cap.data;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (cap.valid) begin
      samp_prev <= cap.data;
      buf_prev  <= line_rd;
    end
  end

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) valid_q <= 1'b0;
    else valid_q <= odd_pix;
  end

  // One pixel per tile
  always_ff @(posedge ccd_pixel_clk) begin
    if (odd_pix) begin
      red_q   <= line_rd;
      green_q <= green_sum[RW:1];  // Mean of both greens, rounded down
      blue_q  <= samp_prev;
    end
  end

  assign rgb.valid = valid_q;
  assign rgb.red   = red_q;
  assign rgb.green = green_q;
  assign rgb.blue  = blue_q;

endmodule : bayer_demosaic

`default_nettype wire

//--- src/cam_defs.svh
`ifndef CAM_DEFS_SVH
`define CAM_DEFS_SVH

// ====================
// Sensor side widths
// ====================
`define CAM_RAW_W      12     // Raw Bayer sample
`define CAM_COORD_W    12     // Pixel/line index and frame size

// Hue works on the top bits of each component only
`define CAM_COMP_W     8

// Samples of one even row kept for the next odd row
`define CAM_LINE_MAX   1280

// ====================
// Pipeline and meter
// ====================
`define CAM_HUE_LAT    3      // Stages in hue_calc

// Frame-rate window, counted in pixel clocks
`define CAM_RATE_TICKS 4096

`define CAM_CNT_W      32     // Frame counter and rate result

`endif

//--- src/cam_pkg.sv
`default_nettype none

`include "cam_defs.svh"

package cam_pkg;

  // ====================
  // Raw sensor sample
  // ====================

  // Registered pin bundle with data on top
  typedef struct packed {
    logic [`CAM_RAW_W-1:0] data;  // Bayer sample
    logic                  fval;  // Frame valid level
    logic                  lval;  // Line valid level
  } raw_sample_t;

  // Column or row index or frame size
  typedef logic [`CAM_COORD_W-1:0] coord_t;

endpackage : cam_pkg

`default_nettype wire

//--- src/cam_stream_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

// ====================
// Captured sample stream
// ====================
interface cap_if import cam_pkg::*; ();
  logic                  valid;        // One active sample
  logic [`CAM_RAW_W-1:0] data;
  coord_t                x;
  coord_t                y;
  logic                  frame_start;  // Single pulse per captured frame

  modport src (output valid, data, x, y, frame_start);
  modport dst (input  valid, data, x, y, frame_start);
endinterface : cap_if

// ====================
// RGB pixel stream
// ====================
interface rgb_if ();
  logic                  valid;
  logic [`CAM_RAW_W-1:0] red;
  logic [`CAM_RAW_W-1:0] green;
  logic [`CAM_RAW_W-1:0] blue;

  modport src (output valid, red, green, blue);
  modport dst (input  valid, red, green, blue);
endinterface : rgb_if

`default_nettype wire

//--- src/capture_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

module capture_ctrl
  import cam_pkg::*;
(
  input  logic                  ccd_pixel_clk,
  input  logic                  arst_n,
  input  raw_sample_t           sample,
  input  logic                  start,
  input  coord_t                width,
  input  coord_t                height,
  cap_if.src                    cap,
  output logic [`CAM_CNT_W-1:0] frame_count,
  output logic [`CAM_CNT_W-1:0] frame_rate,
  output logic                  rate_pulse
);

  localparam int TICK_W = $clog2(`CAM_RATE_TICKS);

  logic                  fval_d;      // Frame valid, last cycle
  logic                  capturing;
  logic                  fval_rise;
  logic                  fval_fall;
  logic                  frame_go;    // Rise seen with start high
  logic                  active;      // Sample belongs to a captured frame
  coord_t                x_cnt;       // Position of the next sample
  coord_t                y_cnt;
  coord_t                cur_x;       // Position of this sample
  coord_t                cur_y;
  logic                  valid_q;
  logic                  frame_start_q;
  logic [`CAM_RAW_W-1:0] data_q;
  coord_t                x_q;
  coord_t                y_q;
  logic [TICK_W-1:0]     tick_cnt;
  logic [`CAM_CNT_W-1:0] count_snap;  // frame_count at last window end

  assign fval_rise = sample.fval & ~fval_d;
  assign fval_fall = ~sample.fval & fval_d;
  assign frame_go  = fval_rise & start;
  assign active    = (capturing | frame_go) & sample.fval & sample.lval;
  assign cur_x     = fval_rise ? '0 : x_cnt;  // Frame restarts at 0,0
  assign cur_y     = fval_rise ? '0 : y_cnt;

  // ====================
  // Gating and coordinates
  // ====================
  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      fval_d        <= 1'b0;
      capturing     <= 1'b0;
      x_cnt         <= '0;
      y_cnt         <= '0;
      valid_q       <= 1'b0;
      frame_start_q <= 1'b0;
    end else begin
      fval_d        <= sample.fval;
      valid_q       <= active;
      frame_start_q <= frame_go;
      if (frame_go) capturing <= 1'b1;        // Armed only at the rise
      else if (fval_fall) capturing <= 1'b0;  // Frame always finished
      if (active) begin
        if (cur_x == width - 1'b1) begin      // End of line, wrap
          x_cnt <= '0;
          y_cnt <= (cur_y == height - 1'b1) ? cur_y : cur_y + 1'b1;
        end else begin
          x_cnt <= cur_x + 1'b1;
          y_cnt <= cur_y;
        end
      end else if (fval_rise) begin
        x_cnt <= '0;
        y_cnt <= '0;
      end
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (active) begin
      data_q <= sample.data;
      x_q    <= cur_x;
      y_q    <= cur_y;
    end
  end

  assign cap.valid       = valid_q;
  assign cap.data        = data_q;
  assign cap.x           = x_q;
  assign cap.y           = y_q;
  assign cap.frame_start = frame_start_q;

  // ====================
  // Frame count and rate meter
  // ====================
  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_count <= '0;
      tick_cnt    <= '0;
      count_snap  <= '0;
      frame_rate  <= '0;
      rate_pulse  <= 1'b0;
    end else begin
      if (frame_start_q) frame_count <= frame_count + 1'b1;
      if (tick_cnt == TICK_W'(`CAM_RATE_TICKS - 1)) begin
        tick_cnt   <= '0;
        frame_rate <= frame_count - count_snap;  // Frames in this window
        count_snap <= frame_count;
        rate_pulse <= ~rate_pulse;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

endmodule : capture_ctrl

`default_nettype wire

//--- src/ccd_pipe_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

module ccd_pipe_top
  import cam_pkg::*;
  import pix_pkg::*;
(
  input  logic                  ccd_pixel_clk,
  input  logic                  arst_n,
  input  logic [`CAM_RAW_W-1:0] ccd_data,
  input  logic                  ccd_fval,
  input  logic                  ccd_lval,
  input  logic                  start,     // Arms capture at frame start
  input  logic                  rgb_mode,  // High for RGB555 words
  input  coord_t                width,
  input  coord_t                height,
  output pix_word_t             pixel_word,
  output logic                  pixel_write,
  output logic [`CAM_CNT_W-1:0] frame_count,
  output logic [`CAM_CNT_W-1:0] frame_rate,
  output logic                  rate_pulse
);

  raw_sample_t pin_sample;  // Pins after one register
  hue_t        hue;

  cap_if cap ();
  rgb_if rgb_raw ();   // Straight from the demosaic
  rgb_if rgb_hue ();   // Delayed to line up with hue

  // ====================
  // Pixel path
  // ====================
  video_delay #(
    .payload_t (raw_sample_t),
    .DEPTH     (1)
  ) pin_reg_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .in_valid      (1'b1),
    .in_data       ({ccd_data, ccd_fval, ccd_lval}),
    .out_valid     (),
    .out_data      (pin_sample)
  );

  capture_ctrl capture_ctrl_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .sample        (pin_sample),
    .start         (start),
    .width         (width),
    .height        (height),
    .cap           (cap.src),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_pulse    (rate_pulse)
  );

  bayer_demosaic bayer_demosaic_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .cap           (cap.dst),
    .rgb           (rgb_raw.src)
  );

  hue_calc hue_calc_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .rgb_in        (rgb_raw.dst),
    .rgb_out       (rgb_hue.src),
    .hue           (hue)
  );

  pixel_packer pixel_packer_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .mode          (pix_mode_e'(rgb_mode)),
    .rgb           (rgb_raw.dst),
    .hue_rgb       (rgb_hue.dst),
    .hue           (hue),
    .word          (pixel_word),
    .write         (pixel_write)
  );

endmodule : ccd_pipe_top

`default_nettype wire

//--- src/hue_calc.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

module hue_calc
  import pix_pkg::*;
(
  input  logic ccd_pixel_clk,
  input  logic arst_n,
  rgb_if.dst   rgb_in,
  rgb_if.src   rgb_out,
  output hue_t hue
);

  localparam int   CW        = `CAM_COMP_W;
  localparam hue_t HUE_OFF_G = 8'd85;   // Green sector start
  localparam hue_t HUE_OFF_B = 8'd171;  // Blue sector start

  logic [CW-1:0]        r;              // Top bits only
  logic [CW-1:0]        g;
  logic [CW-1:0]        b;
  logic [CW-1:0]        mx;
  logic [CW-1:0]        mn;
  logic [1:0]           sect;           // 0 red, 1 green, 2 blue
  logic signed [CW:0]   sdiff;          // Sector difference
  logic                 v1;
  logic                 v2;
  logic [CW-1:0]        s1_diff;
  logic signed [CW:0]   s1_sdiff;
  logic [1:0]           s1_sect;
  logic signed [CW+6:0] num;            // 43 x sector difference
  logic signed [CW+6:0] quot;
  hue_t                 s2_quot;
  hue_t                 s2_off;
  hue_t                 hue_q;
  rgb_pixel_t           in_pix;
  rgb_pixel_t           dly_pix;

  assign r = rgb_in.red[`CAM_RAW_W-1 -: CW];
  assign g = rgb_in.green[`CAM_RAW_W-1 -: CW];
  assign b = rgb_in.blue[`CAM_RAW_W-1 -: CW];

  // Red wins max ties, then green
  always_comb begin
    if (r >= g && r >= b) begin
      sect  = 2'd0;
      mx    = r;
      mn    = (g < b) ? g : b;
      sdiff = $signed({1'b0, g}) - $signed({1'b0, b});
    end else if (g >= b) begin
      sect  = 2'd1;
      mx    = g;
      mn    = (r < b) ? r : b;
      sdiff = $signed({1'b0, b}) - $signed({1'b0, r});
    end else begin
      sect  = 2'd2;
      mx    = b;
      mn    = (r < g) ? r : g;
      sdiff = $signed({1'b0, r}) - $signed({1'b0, g});
    end
  end

  // Signed divide truncates toward zero
  always_comb begin
    num = 7'sd43 * s1_sdiff;
    if (s1_diff == '0) quot = '0;  // Gray pixel
    else quot = num / $signed({1'b0, s1_diff});
  end

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= rgb_in.valid;
      v2 <= v1;
    end
  end

  // ====================
  // Three stages
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rgb_in.valid) begin
      s1_diff  <= mx - mn;
      s1_sdiff <= sdiff;
      s1_sect  <= sect;
    end
    if (v1) begin
      s2_quot <= quot[CW-1:0];  // Two's complement wraps below zero
      s2_off  <= (s1_sect == 2'd0) ? 8'd0 : (s1_sect == 2'd1) ? HUE_OFF_G : HUE_OFF_B;
    end
    if (v2) hue_q <= s2_off + s2_quot;  // Modulo 256
  end

  assign hue    = hue_q;
  assign in_pix = {rgb_in.red, rgb_in.green, rgb_in.blue};

  // Colour travels alongside the hue
  video_delay #(
    .payload_t (rgb_pixel_t),
    .DEPTH     (`CAM_HUE_LAT)
  ) rgb_dly_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .in_valid      (rgb_in.valid),
    .in_data       (in_pix),
    .out_valid     (rgb_out.valid),
    .out_data      (dly_pix)
  );

  assign rgb_out.red   = dly_pix.red;
  assign rgb_out.green = dly_pix.green;
  assign rgb_out.blue  = dly_pix.blue;

endmodule : hue_calc

`default_nettype wire

//--- src/pix_pkg.sv
`default_nettype none

`include "cam_defs.svh"

package pix_pkg;

  // Full-precision reconstructed pixel
  typedef struct packed {
    logic [`CAM_RAW_W-1:0] red;
    logic [`CAM_RAW_W-1:0] green;
    logic [`CAM_RAW_W-1:0] blue;
  } rgb_pixel_t;

  typedef logic [7:0]  hue_t;       // 0..255 around the colour wheel
  typedef logic [15:0] pix_word_t;  // One output word per pixel

  // Output format select, RGB when high
  typedef enum logic {
    MODE_HUE = 1'b0,
    MODE_RGB = 1'b1
  } pix_mode_e;

endpackage : pix_pkg

`default_nettype wire

//--- src/pixel_packer.sv
`default_nettype none
`timescale 1ns/1ps

`include "cam_defs.svh"

module pixel_packer
  import pix_pkg::*;
(
  input  logic      ccd_pixel_clk,
  input  logic      arst_n,
  input  pix_mode_e mode,
  rgb_if.dst        rgb,
  rgb_if.dst        hue_rgb,
  input  hue_t      hue,
  output pix_word_t word,
  output logic      write
);

  localparam int RW = `CAM_RAW_W;

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) write <= 1'b0;
    else if (mode == MODE_RGB) write <= rgb.valid;
    else write <= hue_rgb.valid;  // Hue is aligned with the delayed strobe
  end

  // RGB555 with a spare top bit, or hue in the low byte
  always_ff @(posedge ccd_pixel_clk) begin
    if (mode == MODE_RGB && rgb.valid) begin
      word <= {1'b0, rgb.red[RW-1 -: 5], rgb.green[RW-1 -: 5], rgb.blue[RW-1 -: 5]};
    end else if (mode == MODE_HUE && hue_rgb.valid) begin
      word <= {8'h00, hue};
    end
  end

endmodule : pixel_packer

`default_nettype wire

//--- src/video_delay.sv
`default_nettype none
`timescale 1ns/1ps

module video_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     ccd_pixel_clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic     valid_q [DEPTH];  // Strobe chain
  payload_t data_q  [DEPTH];  // Payload chain, follows the strobe

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    data_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign out_valid = valid_q[DEPTH-1];
  assign out_data  = data_q[DEPTH-1];

endmodule : video_delay

`default_nettype wire
